/* bench/ooo_checker.sv */
/*
 * watches dispatch and commit at the core ports, checks commits in order
 * against a sequential model of the architectural registers
 */
`timescale 1ns/1ps

module ooo_checker (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               dispatch_valid,
    input  logic               stall,
    input  ooo_pkg::areg_t     opa_areg,
    input  ooo_pkg::areg_t     opb_areg,
    input  ooo_pkg::areg_t     dest_areg,
    input  logic               opb_is_imm,
    input  ooo_pkg::word_t     imm,
    input  ooo_pkg::alu_func_t alu_func,
    input  logic               commit_valid,
    input  ooo_pkg::areg_t     commit_dest_areg,
    input  ooo_pkg::word_t     commit_value,
    output int                 value_errors,
    output int                 other_errors,
    output int                 accept_count,
    output int                 commit_count,
    output int                 pending
);
    import ooo_pkg::*;

    typedef struct packed {
        areg_t     opa;
        areg_t     opb;
        areg_t     dest;
        logic      use_imm;
        word_t     imm;
        alu_func_t func;
    } instr_t;

    instr_t instr_q [$];           // accepted, not yet committed
    word_t  arch_regs [AREG_COUNT]; // in-order architectural state

    // expected ALU result, shifts take b[4:0]
    function automatic word_t alu_ref(input alu_func_t f, input word_t a, input word_t b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            // slt, signs differ so the negative one is smaller
            default: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, (a < b)};
        endcase
    endfunction

    always @(posedge clock or negedge rst_n) begin
        instr_t oldest;
        word_t  expected;
        if (!rst_n) begin
            instr_q.delete();
            for (int i = 0; i < AREG_COUNT; i++) arch_regs[i] = '0; // reset state
            value_errors = 0;
            other_errors = 0;
            accept_count = 0;
            commit_count = 0;
            pending      = 0;
        end else begin
            if (commit_valid) begin
                commit_count++;
                if (instr_q.size() == 0) begin
                    other_errors++;
                    $display("commit to register %0d arrived with no instruction pending",
                             commit_dest_areg);
                end else begin
                    oldest   = instr_q.pop_front();
                    expected = alu_ref(oldest.func, arch_regs[oldest.opa],
                                       oldest.use_imm ? oldest.imm : arch_regs[oldest.opb]);
                    if (commit_dest_areg !== oldest.dest) begin
                        value_errors++;
                        $display("** Error: commit_dest_areg = 0x%02h, expected 0x%02h",
                                 commit_dest_areg, oldest.dest);
                    end
                    if (commit_value !== expected) begin
                        value_errors++;
                        $display("** Error: commit_value = 0x%08h, expected 0x%08h",
                                 commit_value, expected);
                    end
                    if (oldest.dest != '0) arch_regs[oldest.dest] = expected; // x0 stays 0
                end
            end
            // accepted at this edge, stall seen before the edge
            if (dispatch_valid && !stall) begin
                instr_q.push_back('{opa_areg, opb_areg, dest_areg, opb_is_imm, imm, alu_func});
                accept_count++;
            end
            pending = instr_q.size();
        end
    end

endmodule

/* bench/tb_ooo_core.sv */
/*
 * directed and random instruction streams for the core
 * inputs change on falling edges, the checker samples on rising edges
 */
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int TOTAL_INSTR    = 18 + 24 + 40 + 6 + 400; // tests 1 to 5
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_INSTR + 200;

    logic        clock;
    logic        rst_n;
    logic        dispatch_valid;
    areg_t       opa_areg;
    areg_t       opb_areg;
    areg_t       dest_areg;
    logic        opb_is_imm;
    word_t       imm;
    alu_func_t   alu_func;
    logic        stall;
    logic        commit_valid;
    areg_t       commit_dest_areg;
    word_t       commit_value;
    int          value_errors;
    int          other_errors;
    int          accept_count;
    int          commit_count;
    int          pending;
    int          bench_errors;
    int          cycles;
    logic        stall_seen;
    integer      seed;
    logic [31:0] rnd;

    ooo_core dut (.*);

    ooo_checker commit_check (.*);

    always #10 clock = ~clock; // 20 ns period

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d instructions pending", cycles, pending);
            $display("Test failed");
            $finish;
        end
    end

    // hold one instruction until an edge accepts it
    task automatic send(input alu_func_t f, input areg_t a, input areg_t b, input areg_t d,
                        input logic use_imm, input word_t value);
        @(negedge clock);
        alu_func       = f;
        opa_areg       = a;
        opb_areg       = b;
        dest_areg      = d;
        opb_is_imm     = use_imm;
        imm            = value;
        dispatch_valid = 1'b1;
        while (stall) begin          // only changes at rising edges
            stall_seen = 1'b1;
            @(negedge clock);
        end
        @(posedge clock);            // accepting edge
    endtask

    task automatic drain();
        @(negedge clock);
        dispatch_valid = 1'b0;
        while (pending != 0) @(negedge clock);
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        dispatch_valid = 1'b0;
        opa_areg = '0;
        opb_areg = '0;
        dest_areg = '0;
        opb_is_imm = 1'b0;
        imm = '0;
        alu_func = ALU_ADD;
        bench_errors = 0;
        stall_seen = 1'b0;
        seed = 92;
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        //////////////////////////////////////////////////////////////////////
        // 1: operand loads, then each function with and without immediate
        send(ALU_ADD, 5'd0, 5'd0, 5'd1, 1'b1, 32'h8765_4321);
        send(ALU_ADD, 5'd0, 5'd0, 5'd2, 1'b1, 32'h0000_0013);
        for (int f = 0; f < 8; f++) begin
            send(alu_func_t'(f), 5'd1, 5'd2, areg_t'(3 + f), 1'b0, '0);
            send(alu_func_t'(f), 5'd2, 5'd0, areg_t'(11 + f), 1'b1, 32'hfff0_0005 + f);
        end
        drain();

        // 2: chains, each reads the previous destination
        for (int i = 0; i < 12; i++) begin
            send(alu_func_t'(i), areg_t'(i == 0 ? 1 : 5 + i), 5'd2, areg_t'(6 + i), 1'b0, '0);
        end
        for (int i = 0; i < 12; i++) begin
            send(alu_func_t'(i + 3), 5'd20, 5'd0, 5'd20, 1'b1, 32'h1357_0000 + i);
        end
        drain();

        // 3: serial chain back to back, window has to fill
        stall_seen = 1'b0;
        for (int i = 0; i < 40; i++) send(ALU_ADD, 5'd21, 5'd1, 5'd21, 1'b0, '0);
        if (!stall_seen) begin
            bench_errors++;
            $display("stall never went high during the back-to-back dependency chain");
        end
        drain();

        // 4: x0 as destination, later reads must see zero
        send(ALU_ADD, 5'd1, 5'd2, 5'd0, 1'b0, '0);
        send(ALU_XOR, 5'd0, 5'd0, 5'd0, 1'b1, 32'hdead_beef);
        send(ALU_OR,  5'd0, 5'd1, 5'd22, 1'b0, '0);
        send(ALU_SUB, 5'd2, 5'd0, 5'd23, 1'b0, '0);
        send(ALU_ADD, 5'd0, 5'd0, 5'd24, 1'b1, 32'h0000_0042);
        send(ALU_SLT, 5'd0, 5'd1, 5'd25, 1'b0, '0);
        drain();

        // 5: random stream over all registers and functions
        for (int n = 0; n < 400; n++) begin
            rnd = $random(seed);
            send(alu_func_t'(rnd[2:0]), rnd[7:3], rnd[12:8], rnd[17:13], rnd[18], $random(seed));
        end
        drain();
        //////////////////////////////////////////////////////////////////////

        if (accept_count != TOTAL_INSTR || commit_count != accept_count) begin
            bench_errors++;
            $display("sent %0d instructions, %0d accepted, %0d committed",
                     TOTAL_INSTR, accept_count, commit_count);
        end
        $display("errors: value %0d, commit %0d, bench %0d", value_errors, other_errors,
                 bench_errors);
        if (value_errors + other_errors + bench_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* design/alu_unit.sv */
/*
 * single-cycle ALU with a registered result, sole driver of the bus
 * cdb_valid pulses one cycle after each issue edge
 */
`timescale 1ns/1ps

module alu_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  ooo_pkg::word_t     issue_opa,
    input  ooo_pkg::word_t     issue_opb,
    input  ooo_pkg::alu_func_t issue_func,
    input  ooo_pkg::preg_t     issue_preg,
    input  logic               issue_write,
    input  ooo_pkg::rob_idx_t  issue_rob_idx,
    output logic               cdb_valid,
    output logic               cdb_write,
    output ooo_pkg::preg_t     cdb_preg,
    output ooo_pkg::rob_idx_t  cdb_rob_idx,
    output ooo_pkg::word_t     cdb_value
);
    import ooo_pkg::*;

    word_t result;

    always_comb begin
        case (issue_func)
            ALU_ADD: result = issue_opa + issue_opb;
            ALU_SUB: result = issue_opa - issue_opb;
            ALU_AND: result = issue_opa & issue_opb;
            ALU_OR:  result = issue_opa | issue_opb;
            ALU_XOR: result = issue_opa ^ issue_opb;
            ALU_SLL: result = issue_opa << issue_opb[4:0];
            ALU_SRL: result = issue_opa >> issue_opb[4:0];   // logical
            default: result = word_t'($signed(issue_opa) < $signed(issue_opb)); // slt
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) cdb_valid <= 1'b0;
        else        cdb_valid <= issue_valid;
    end

    // tags ride along with the value
    always_ff @(posedge clock) begin
        cdb_write   <= issue_write;
        cdb_preg    <= issue_preg;
        cdb_rob_idx <= issue_rob_idx;
        cdb_value   <= result;
    end

endmodule

/* design/ooo_core.sv */
/*
 * ALU-only out-of-order core, one decoded instruction per cycle
 * source must hold its inputs while stall is high
 */
`timescale 1ns/1ps

module ooo_core (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               dispatch_valid,
    input  ooo_pkg::areg_t     opa_areg,
    input  ooo_pkg::areg_t     opb_areg,
    input  ooo_pkg::areg_t     dest_areg,
    input  logic               opb_is_imm,
    input  ooo_pkg::word_t     imm,
    input  ooo_pkg::alu_func_t alu_func,
    output logic               stall,
    output logic               commit_valid,
    output ooo_pkg::areg_t     commit_dest_areg,
    output ooo_pkg::word_t     commit_value
);
    import ooo_pkg::*;

    logic      dispatch_fire;
    preg_t     opa_preg;          // rename -> prf, rs
    preg_t     opb_preg;
    preg_t     dest_preg;
    preg_t     prev_preg;         // rename -> rob
    logic      dest_write;
    logic      rob_full;
    logic      rs_full;
    logic      commit_free_valid; // rob -> free list
    preg_t     commit_prev_preg;
    word_t     opa_value;         // prf -> rs
    word_t     opb_value;
    logic      opa_ready;
    logic      opb_ready;
    rob_idx_t  rob_tail;

    // rs -> alu
    logic      issue_valid;
    word_t     issue_opa;
    word_t     issue_opb;
    alu_func_t issue_func;
    preg_t     issue_preg;
    logic      issue_write;
    rob_idx_t  issue_rob_idx;

    // result bus, alu is the only driver
    logic      cdb_valid;
    logic      cdb_write;
    preg_t     cdb_preg;
    rob_idx_t  cdb_rob_idx;
    word_t     cdb_value;

    rename_ctrl rename_ctrl0 (.*);

    prf prf0 (.*);

    rs_alu rs_alu0 (.*);

    alu_unit alu_unit0 (.*);

    rob rob0 (.*);

endmodule

/* design/ooo_pkg.sv */
/*
 * sizes, vector types and ALU function codes shared by the core
 * widths of the index types must track the counts below
 */
package ooo_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int AREG_COUNT = 32;                      // architectural regs
    localparam int PREG_COUNT = 64;                      // physical regs
    localparam int ROB_SIZE   = 16;
    localparam int RS_SIZE    = 8;
    localparam int FREE_COUNT = PREG_COUNT - AREG_COUNT; // free list depth

    //////////////////////////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////////////////////////
    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      areg_t;    // log2 AREG_COUNT
    typedef logic [5:0]      preg_t;    // log2 PREG_COUNT
    typedef logic [3:0]      rob_idx_t; // log2 ROB_SIZE
    typedef logic [2:0]      alu_func_t;

    // ALU functions, shifts take b[4:0]
    localparam alu_func_t ALU_ADD = 3'd0;
    localparam alu_func_t ALU_SUB = 3'd1;
    localparam alu_func_t ALU_AND = 3'd2;
    localparam alu_func_t ALU_OR  = 3'd3;
    localparam alu_func_t ALU_XOR = 3'd4;
    localparam alu_func_t ALU_SLL = 3'd5;
    localparam alu_func_t ALU_SRL = 3'd6;
    localparam alu_func_t ALU_SLT = 3'd7; // signed, yields 0 or 1

endpackage

/* design/prf.sv */
/*
 * physical register values and ready bits, bus bypass on both reads
 * phys reg 0 is hardwired zero and always ready
 */
`timescale 1ns/1ps

module prf (
    input  logic           clock,
    input  logic           rst_n,
    input  ooo_pkg::preg_t opa_preg,
    input  ooo_pkg::preg_t opb_preg,
    input  ooo_pkg::preg_t dest_preg,
    input  logic           dispatch_fire,
    input  logic           dest_write,
    input  logic           cdb_valid,
    input  logic           cdb_write,
    input  ooo_pkg::preg_t cdb_preg,
    input  ooo_pkg::word_t cdb_value,
    output ooo_pkg::word_t opa_value,
    output ooo_pkg::word_t opb_value,
    output logic           opa_ready,
    output logic           opb_ready
);
    import ooo_pkg::*;

    word_t                 values [PREG_COUNT];
    logic [PREG_COUNT-1:0] ready;
    logic                  cdb_wr;
    logic                  hit_a;
    logic                  hit_b;

    assign cdb_wr = cdb_valid & cdb_write & (cdb_preg != '0); // reg 0 stays zero
    assign hit_a  = cdb_wr && (cdb_preg == opa_preg);
    assign hit_b  = cdb_wr && (cdb_preg == opb_preg);

    assign opa_value = hit_a ? cdb_value : values[opa_preg];
    assign opb_value = hit_b ? cdb_value : values[opb_preg];
    assign opa_ready = hit_a | ready[opa_preg];
    assign opb_ready = hit_b | ready[opb_preg];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PREG_COUNT; i++) begin
                values[i] <= '0;
                ready[i]  <= (i < AREG_COUNT); // initial arch state
            end
        end else begin
            if (dispatch_fire && dest_write) begin
                ready[dest_preg] <= 1'b0;      // new producer in flight
            end
            if (cdb_wr) begin
                values[cdb_preg] <= cdb_value;
                ready[cdb_preg]  <= 1'b1;
            end
        end
    end

endmodule

/* design/rename_ctrl.sv */
/*
 * rename table plus circular free list of physical registers
 * reg 0 is never renamed and always reads physical reg 0
 */
`timescale 1ns/1ps

module rename_ctrl (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           dispatch_valid,
    input  ooo_pkg::areg_t opa_areg,
    input  ooo_pkg::areg_t opb_areg,
    input  ooo_pkg::areg_t dest_areg,
    input  logic           rob_full,
    input  logic           rs_full,
    input  logic           commit_free_valid,
    input  ooo_pkg::preg_t commit_prev_preg,
    output logic           stall,
    output logic           dispatch_fire,
    output ooo_pkg::preg_t opa_preg,
    output ooo_pkg::preg_t opb_preg,
    output ooo_pkg::preg_t dest_preg,
    output ooo_pkg::preg_t prev_preg,
    output logic           dest_write
);
    import ooo_pkg::*;

    preg_t rat [AREG_COUNT];       // arch -> phys map
    preg_t free_list [FREE_COUNT];
    logic [$clog2(FREE_COUNT)-1:0] fl_head; // pop side
    logic [$clog2(FREE_COUNT)-1:0] fl_tail; // push side
    logic [$clog2(FREE_COUNT):0]   fl_count;
    logic                          pop;

    assign stall         = rob_full | rs_full | (fl_count == '0);
    assign dispatch_fire = dispatch_valid & ~stall;
    assign dest_write    = (dest_areg != '0);
    assign pop           = dispatch_fire & dest_write;

    // sources see the mapping before this dispatch's update
    assign opa_preg  = rat[opa_areg];
    assign opb_preg  = rat[opb_areg];
    assign prev_preg = rat[dest_areg];
    assign dest_preg = dest_write ? free_list[fl_head] : '0;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < AREG_COUNT; i++) begin
                rat[i] <= preg_t'(i);              // identity map
            end
            for (int i = 0; i < FREE_COUNT; i++) begin
                free_list[i] <= preg_t'(AREG_COUNT + i); // 32..63
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= FREE_COUNT[$clog2(FREE_COUNT):0];
        end else begin
            if (pop) begin
                rat[dest_areg] <= free_list[fl_head];
                fl_head        <= fl_head + 1'b1;
            end
            // old mapping comes back once its overwriter commits
            if (commit_free_valid) begin
                free_list[fl_tail] <= commit_prev_preg;
                fl_tail            <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + commit_free_valid - pop; // both may hit at once
        end
    end

endmodule

/* design/rob.sv */
/*
 * circular reorder buffer, commits the head once done, one per cycle
 * commit outputs are registered, so commit trails completion by an edge
 */
`timescale 1ns/1ps

module rob (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              dispatch_fire,
    input  ooo_pkg::areg_t    dest_areg,
    input  logic              dest_write,
    input  ooo_pkg::preg_t    prev_preg,
    input  logic              cdb_valid,
    input  ooo_pkg::rob_idx_t cdb_rob_idx,
    input  ooo_pkg::word_t    cdb_value,
    output ooo_pkg::rob_idx_t rob_tail,
    output logic              rob_full,
    output logic              commit_valid,
    output ooo_pkg::areg_t    commit_dest_areg,
    output ooo_pkg::word_t    commit_value,
    output logic              commit_free_valid,
    output ooo_pkg::preg_t    commit_prev_preg
);
    import ooo_pkg::*;

    areg_t                     dest [ROB_SIZE];
    logic [ROB_SIZE-1:0]       wr;
    preg_t                     prev [ROB_SIZE];
    logic [ROB_SIZE-1:0]       done;
    word_t                     value [ROB_SIZE];
    rob_idx_t                  head;
    rob_idx_t                  tail;
    logic [$clog2(ROB_SIZE):0] count;
    logic                      commit_now;

    assign rob_tail   = tail;
    assign rob_full   = (count == ROB_SIZE[$clog2(ROB_SIZE):0]);
    assign commit_now = (count != '0) && done[head];

    //////////////////////////////////////////////////////////////////////
    // pointers, done bits and commit strobes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head              <= '0;
            tail              <= '0;
            count             <= '0;
            done              <= '0;
            commit_valid      <= 1'b0;
            commit_free_valid <= 1'b0;
        end else begin
            if (dispatch_fire) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1; // 16 entries, wraps by itself
            end
            if (cdb_valid) done[cdb_rob_idx] <= 1'b1; // completion
            if (commit_now) head <= head + 1'b1;
            count             <= count + dispatch_fire - commit_now;
            commit_valid      <= commit_now;
            commit_free_valid <= commit_now & wr[head]; // reg 0 frees nothing
        end
    end

    // entry payload and commit data
    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            dest[tail] <= dest_areg;
            wr[tail]   <= dest_write;
            prev[tail] <= prev_preg;
        end
        if (cdb_valid) value[cdb_rob_idx] <= cdb_value;
        commit_dest_areg <= dest[head];
        commit_value     <= value[head];
        commit_prev_preg <= prev[head];
    end

endmodule

/* design/rs_alu.sv */
/*
 * ALU reservation station, fills the lowest free slot
 * issues the lowest-index entry with both operands ready
 */
`timescale 1ns/1ps

module rs_alu (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               dispatch_fire,
    input  logic               opa_ready,
    input  ooo_pkg::word_t     opa_value,
    input  logic               opb_ready,
    input  ooo_pkg::word_t     opb_value,
    input  ooo_pkg::preg_t     opa_preg,
    input  ooo_pkg::preg_t     opb_preg,
    input  logic               opb_is_imm,
    input  ooo_pkg::word_t     imm,
    input  ooo_pkg::alu_func_t alu_func,
    input  ooo_pkg::preg_t     dest_preg,
    input  logic               dest_write,
    input  ooo_pkg::rob_idx_t  rob_tail,
    input  logic               cdb_valid,
    input  logic               cdb_write,
    input  ooo_pkg::preg_t     cdb_preg,
    input  ooo_pkg::word_t     cdb_value,
    output logic               rs_full,
    output logic               issue_valid,
    output ooo_pkg::word_t     issue_opa,
    output ooo_pkg::word_t     issue_opb,
    output ooo_pkg::alu_func_t issue_func,
    output ooo_pkg::preg_t     issue_preg,
    output logic               issue_write,
    output ooo_pkg::rob_idx_t  issue_rob_idx
);
    import ooo_pkg::*;

    logic [RS_SIZE-1:0] valid;
    logic [RS_SIZE-1:0] a_rdy;
    logic [RS_SIZE-1:0] b_rdy;
    word_t              a_val [RS_SIZE];
    word_t              b_val [RS_SIZE];
    preg_t              a_tag [RS_SIZE];
    preg_t              b_tag [RS_SIZE];
    alu_func_t          func [RS_SIZE];
    preg_t              dst [RS_SIZE];
    logic [RS_SIZE-1:0] wr;
    rob_idx_t           rob_idx [RS_SIZE];

    logic [$clog2(RS_SIZE)-1:0] free_slot;
    logic [$clog2(RS_SIZE)-1:0] iss_slot;
    logic                       cdb_hit;
    logic                       in_a_rdy;
    logic                       in_b_rdy;

    assign rs_full = &valid;
    assign cdb_hit = cdb_valid & cdb_write;

    // incoming entry also catches a broadcast in its own cycle
    assign in_a_rdy = opa_ready | (cdb_hit && cdb_preg == opa_preg);
    assign in_b_rdy = opb_is_imm | opb_ready | (cdb_hit && cdb_preg == opb_preg);

    // scan high to low so the lowest index wins
    always_comb begin
        free_slot   = '0;
        iss_slot    = '0;
        issue_valid = 1'b0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!valid[i]) free_slot = i[$clog2(RS_SIZE)-1:0];
            if (valid[i] && a_rdy[i] && b_rdy[i]) begin
                iss_slot    = i[$clog2(RS_SIZE)-1:0];
                issue_valid = 1'b1;
            end
        end
    end

    assign issue_opa     = a_val[iss_slot];
    assign issue_opb     = b_val[iss_slot];
    assign issue_func    = func[iss_slot];
    assign issue_preg    = dst[iss_slot];
    assign issue_write   = wr[iss_slot];
    assign issue_rob_idx = rob_idx[iss_slot];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (issue_valid)   valid[iss_slot]  <= 1'b0; // slot freed at issue
            if (dispatch_fire) valid[free_slot] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        // wakeup of held operands
        for (int i = 0; i < RS_SIZE; i++) begin
            if (cdb_hit && !a_rdy[i] && a_tag[i] == cdb_preg) begin
                a_rdy[i] <= 1'b1;
                a_val[i] <= cdb_value;
            end
            if (cdb_hit && !b_rdy[i] && b_tag[i] == cdb_preg) begin
                b_rdy[i] <= 1'b1;
                b_val[i] <= cdb_value;
            end
        end
        if (dispatch_fire) begin
            a_rdy[free_slot]   <= in_a_rdy;
            a_val[free_slot]   <= opa_ready ? opa_value : cdb_value;
            a_tag[free_slot]   <= opa_preg;
            b_rdy[free_slot]   <= in_b_rdy;
            b_val[free_slot]   <= opb_is_imm ? imm : (opb_ready ? opb_value : cdb_value);
            b_tag[free_slot]   <= opb_preg;
            func[free_slot]    <= alu_func;
            dst[free_slot]     <= dest_preg;
            wr[free_slot]      <= dest_write;
            rob_idx[free_slot] <= rob_tail;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# compile and run the core testbench with verilator, pass is read from the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_ooo_core -o tb_ooo_core \
    && ./obj_dir/tb_ooo_core > sim.log 2>&1 \
    || { echo "verilator build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* src.f */
design/ooo_pkg.sv
design/rename_ctrl.sv
design/prf.sv
design/rs_alu.sv
design/alu_unit.sv
design/rob.sv
design/ooo_core.sv
bench/ooo_checker.sv
bench/tb_ooo_core.sv
